/* boot_rom.hex */
// One 32-bit word per line in hex, word addresses 0 to 15.
00000013
10000137
30000237
0ff00293
00512023
00022303
00130313
00612223
fe5ff06f
deadbeef
0badf00d
12345678
9abcdef0
00000000
ffffffff
a5a55a5a

/* soc_bus.f */
design/soc_bus_pkg.sv
design/axil_decoder.sv
design/boot_rom.sv
design/axil_ram.sv
design/uart_periph.sv
design/soc_bus_top.sv
verification/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 -f soc_bus.f \
        --top-module soc_bus_tb -o soc_bus_sim \
    && ./obj_dir/soc_bus_sim \
    || { echo "Simulation failed."; exit 1; }

/* verification/soc_bus_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL} op_kind_t;

    typedef struct packed {
        op_kind_t   kind;
        axil_addr_t addr;
        axil_data_t data;       // Write data, or bit mask for a poll.
        axil_strb_t strb;
        axil_data_t exp_data;
        axil_resp_t exp_resp;
    } table_entry_t;

    logic       clk = 1'b0;
    logic       rst;
    axil_aw_t   s_aw;
    logic       s_awvalid;
    logic       s_awready;
    axil_w_t    s_w;
    logic       s_wvalid;
    logic       s_wready;
    axil_resp_t s_bresp;
    logic       s_bvalid;
    logic       s_bready;
    axil_ar_t   s_ar;
    logic       s_arvalid;
    logic       s_arready;
    axil_r_t    s_r;
    logic       s_rvalid;
    logic       s_rready;
    logic       uart_tx;
    logic       uart_rx;

    table_entry_t stim_table[$];
    axil_data_t   rom_image [ROM_WORDS];
    axil_data_t   ram_model [RAM_WORDS];
    logic         ram_known [RAM_WORDS];
    uart_byte_t   tx_expect[$];  // Bytes the transmitter must send.
    uart_byte_t   line_byte;
    int           cycle_count = 0;
    int           cycle_limit;

    soc_bus_top dut0 (.*);

    assign uart_rx = uart_tx;  // Loopback.

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the test sequence did not finish within %0d cycles.", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "Simulation stopped on timeout.");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    // Frame monitor on the serial line, 8N1 and LSB first.
    always @(negedge clk) begin
        if (!rst && uart_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_line("uart_tx start bit", 1'b0, uart_tx);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                line_byte[b] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_line("uart_tx stop bit", 1'b1, uart_tx);
            if (tx_expect.size() == 0) begin
                abort_run("A frame appeared on uart_tx without an accepted TXDATA write.");
            end
            check_byte("uart_tx data", tx_expect.pop_front(), line_byte);
        end
    end

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, output axil_resp_t resp);
        @(posedge clk);
        s_aw      <= '{addr: addr, prot: 3'b000};
        s_w       <= '{data: data, strb: strb};
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        s_bready  <= 1'b1;
        do @(negedge clk); while (!(s_awready && s_wready));
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        do @(negedge clk); while (!s_bvalid);
        resp = s_bresp;
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        @(posedge clk);
        s_ar      <= '{addr: addr, prot: 3'b000};
        s_arvalid <= 1'b1;
        s_rready  <= 1'b1;
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        s_arvalid <= 1'b0;
        do @(negedge clk); while (!s_rvalid);
        data = s_r.data;
        resp = s_r.resp;
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    function automatic void add_entry(input op_kind_t kind, input axil_addr_t addr,
                                      input axil_data_t data, input axil_strb_t strb,
                                      input axil_data_t exp_data, input axil_resp_t exp_resp);
        table_entry_t e;
        e.kind     = kind;
        e.addr     = addr;
        e.data     = data;
        e.strb     = strb;
        e.exp_data = exp_data;
        e.exp_resp = exp_resp;
        stim_table.push_back(e);
    endfunction

    // RAM word index is address bits 11:2.
    function automatic void ram_write(input axil_addr_t addr, input axil_data_t data,
                                      input axil_strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) ram_model[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
        if (strb == 4'hf) ram_known[addr[11:2]] = 1'b1;
        add_entry(OP_WRITE, addr, data, strb, '0, RESP_OKAY);
    endfunction

    function automatic void ram_read(input axil_addr_t addr);
        add_entry(OP_READ, addr, '0, '0, ram_model[addr[11:2]], RESP_OKAY);
    endfunction

    function automatic void build_table();
        logic [31:0] rnd;
        logic [31:0] alias_rnd;
        axil_addr_t  addr;
        axil_strb_t  strb;

        // Byte strobes on two words.
        ram_write(32'h1000_0040, 32'h1122_3344, 4'hf);
        ram_write(32'h1000_0040, 32'haabb_ccdd, 4'h1);
        ram_write(32'h1000_0040, 32'h5566_7788, 4'ha);
        ram_write(32'h1000_0040, 32'h99ee_ff00, 4'h4);
        ram_write(32'h1000_0044, 32'hcafe_babe, 4'hf);
        ram_write(32'h1000_0044, 32'h0f0f_0f0f, 4'h6);
        ram_read(32'h1000_0040);
        ram_read(32'h1000_0044);

        for (int n = 0; n < 40; n++) begin
            rnd       = $urandom;
            alias_rnd = $urandom;
            addr      = {REGION_RAM, rnd[27:2], 2'b00};
            strb      = axil_strb_t'($urandom_range(15, 1));
            if (!ram_known[addr[11:2]]) ram_write(addr, $urandom, 4'hf);
            ram_write(addr, $urandom, strb);
            ram_read({REGION_RAM, alias_rnd[27:12], addr[11:0]});  // Aliased copy.
        end

        for (int i = 0; i < ROM_WORDS; i++) begin
            add_entry(OP_READ, 32'(i * 4), '0, '0, rom_image[i], RESP_OKAY);
        end
        add_entry(OP_READ, 32'h0abc_0044, '0, '0, rom_image[1], RESP_OKAY);
        add_entry(OP_WRITE, 32'h0000_0014, 32'hffff_ffff, 4'hf, '0, RESP_SLVERR);
        add_entry(OP_READ, 32'h0000_0014, '0, '0, rom_image[5], RESP_OKAY);

        add_entry(OP_READ, 32'h2000_0000, '0, '0, '0, RESP_DECERR);
        add_entry(OP_WRITE, 32'h2000_0000, 32'h1234_5678, 4'hf, '0, RESP_DECERR);
        add_entry(OP_READ, 32'h7000_0010, '0, '0, '0, RESP_DECERR);
        add_entry(OP_WRITE, 32'h7000_0000, 32'h8765_4321, 4'hf, '0, RESP_DECERR);

        add_entry(OP_WRITE, 32'h3000_0000, 32'h0000_00a5, 4'hf, '0, RESP_OKAY);
        add_entry(OP_WRITE, 32'h3000_0000, 32'h0000_003c, 4'hf, '0, RESP_SLVERR);
        add_entry(OP_POLL, 32'h3000_0004, 32'h0000_0002, '0, '0, RESP_OKAY);
        add_entry(OP_READ, 32'h3000_0008, '0, '0, 32'h0000_00a5, RESP_OKAY);
        add_entry(OP_READ, 32'h3000_0004, '0, '0, 32'h0000_0000, RESP_OKAY);
        add_entry(OP_READ, 32'h3000_000c, '0, '0, 32'h0000_0000, RESP_SLVERR);
    endfunction

    initial begin
        table_entry_t e;
        axil_resp_t   resp;
        axil_data_t   rdata;
        int           uart_entries;

        rst       <= 1'b1;
        s_aw      <= '0;
        s_awvalid <= 1'b0;
        s_w       <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b0;
        s_ar      <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b0;

        void'($urandom(32'h1ff1));
        $readmemh(ROM_FILE, rom_image);
        for (int i = 0; i < RAM_WORDS; i++) ram_known[i] = 1'b0;
        build_table();

        uart_entries = 0;
        foreach (stim_table[i]) begin
            if (stim_table[i].addr[31:28] == REGION_UART) uart_entries++;
        end
        cycle_limit = 10 + stim_table.size() * 20 + uart_entries * 4 * 10 * CLKS_PER_BIT;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        foreach (stim_table[i]) begin
            e = stim_table[i];
            case (e.kind)
                OP_WRITE: begin
                    if (e.addr[31:28] == REGION_UART && e.addr[3:0] == UART_TXDATA[3:0]
                            && e.exp_resp == RESP_OKAY) begin
                        tx_expect.push_back(e.data[7:0]);
                    end
                    axil_write(e.addr, e.data, e.strb, resp);
                    check_resp("s_bresp", e.exp_resp, resp);
                end
                OP_READ: begin
                    axil_read(e.addr, rdata, resp);
                    check_resp("s_r.resp", e.exp_resp, resp);
                    check_data("s_r.data", e.exp_data, rdata);
                end
                default: begin
                    do begin
                        axil_read(e.addr, rdata, resp);
                        check_resp("s_r.resp", e.exp_resp, resp);
                    end while ((rdata & e.data) == '0);
                end
            endcase
        end

        if (tx_expect.size() != 0) begin
            abort_run("An accepted TXDATA byte never appeared on uart_tx.");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* design/soc_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  axil_aw_t   s_aw,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  axil_w_t    s_w,
    input  logic       s_wvalid,
    output logic       s_wready,
    output axil_resp_t s_bresp,
    output logic       s_bvalid,
    input  logic       s_bready,
    input  axil_ar_t   s_ar,
    input  logic       s_arvalid,
    output logic       s_arready,
    output axil_r_t    s_r,
    output logic       s_rvalid,
    input  logic       s_rready,

    output logic       uart_tx,
    input  logic       uart_rx
);
    axil_aw_t   rom_aw, ram_aw, uart_aw;
    axil_w_t    rom_w, ram_w, uart_w;
    axil_ar_t   rom_ar, ram_ar, uart_ar;
    axil_r_t    rom_r, ram_r, uart_r;
    axil_resp_t rom_bresp, ram_bresp, uart_bresp;
    logic       rom_awvalid, rom_awready, rom_wvalid, rom_wready, rom_bvalid, rom_bready;
    logic       rom_arvalid, rom_arready, rom_rvalid, rom_rready;
    logic       ram_awvalid, ram_awready, ram_wvalid, ram_wready, ram_bvalid, ram_bready;
    logic       ram_arvalid, ram_arready, ram_rvalid, ram_rready;
    logic       uart_awvalid, uart_awready, uart_wvalid, uart_wready, uart_bvalid, uart_bready;
    logic       uart_arvalid, uart_arready, uart_rvalid, uart_rready;

    axil_decoder decoder0 (.*);

    boot_rom rom0 (
        .clk (clk),
        .rst (rst),
        .aw (rom_aw), .awvalid (rom_awvalid), .awready (rom_awready),
        .w (rom_w), .wvalid (rom_wvalid), .wready (rom_wready),
        .bresp (rom_bresp), .bvalid (rom_bvalid), .bready (rom_bready),
        .ar (rom_ar), .arvalid (rom_arvalid), .arready (rom_arready),
        .r (rom_r), .rvalid (rom_rvalid), .rready (rom_rready)
    );

    axil_ram ram0 (
        .clk (clk),
        .rst (rst),
        .aw (ram_aw), .awvalid (ram_awvalid), .awready (ram_awready),
        .w (ram_w), .wvalid (ram_wvalid), .wready (ram_wready),
        .bresp (ram_bresp), .bvalid (ram_bvalid), .bready (ram_bready),
        .ar (ram_ar), .arvalid (ram_arvalid), .arready (ram_arready),
        .r (ram_r), .rvalid (ram_rvalid), .rready (ram_rready)
    );

    uart_periph uart0 (
        .clk (clk),
        .rst (rst),
        .aw (uart_aw), .awvalid (uart_awvalid), .awready (uart_awready),
        .w (uart_w), .wvalid (uart_wvalid), .wready (uart_wready),
        .bresp (uart_bresp), .bvalid (uart_bvalid), .bready (uart_bready),
        .ar (uart_ar), .arvalid (uart_arvalid), .arready (uart_arready),
        .r (uart_r), .rvalid (uart_rvalid), .rready (uart_rready),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx)
    );

endmodule

`default_nettype wire

/* design/uart_periph.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_periph import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  axil_aw_t   aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_resp_t bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_ar_t   ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready,

    output logic       uart_tx,
    input  logic       uart_rx
);
    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

    uart_state_t tx_state;
    uart_state_t rx_state;
    baud_cnt_t   tx_cnt;
    baud_cnt_t   rx_cnt;
    logic [2:0]  tx_bits;
    logic [2:0]  rx_bits;
    uart_byte_t  tx_shift;
    uart_byte_t  rx_shift;
    uart_byte_t  rx_data;
    logic        rx_valid;
    logic [1:0]  rx_sync;
    logic        tx_busy;
    logic        wr_tx;
    logic        tx_start;
    logic        rx_rd;

    assign awready  = awvalid && wvalid && !bvalid;
    assign wready   = awready;
    assign arready  = arvalid && !rvalid;
    assign tx_busy  = tx_state != IDLE;
    assign wr_tx    = aw.addr[3:0] == UART_TXDATA[3:0];
    assign tx_start = awready && wr_tx && !tx_busy;
    assign rx_rd    = arready && ar.addr[3:0] == UART_RXDATA[3:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (awready) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (arready) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awready) bresp <= (wr_tx && !tx_busy) ? RESP_OKAY : RESP_SLVERR;
        if (arready) begin
            case (ar.addr[3:0])
                UART_TXDATA[3:0]: r <= '{data: '0, resp: RESP_OKAY};
                UART_STATUS[3:0]: r <= '{data: {30'd0, rx_valid, tx_busy}, resp: RESP_OKAY};
                UART_RXDATA[3:0]: r <= '{data: {24'd0, rx_data}, resp: RESP_OKAY};
                default:          r <= '{data: '0, resp: RESP_SLVERR};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= IDLE;
            uart_tx  <= 1'b1;
        end else begin
            case (tx_state)
                IDLE: if (tx_start) begin
                    tx_state <= START;
                    tx_shift <= w.data[7:0];
                    tx_cnt   <= '0;
                    uart_tx  <= 1'b0;  // Start bit.
                end
                START: if (tx_cnt == BIT_LAST) begin
                    tx_state <= DATA;
                    tx_cnt   <= '0;
                    tx_bits  <= '0;
                    uart_tx  <= tx_shift[0];
                end else begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
                DATA: if (tx_cnt == BIT_LAST) begin
                    tx_cnt <= '0;
                    if (tx_bits == 3'd7) begin
                        tx_state <= STOP;
                        uart_tx  <= 1'b1;
                    end else begin
                        tx_bits  <= tx_bits + 1'b1;
                        tx_shift <= tx_shift >> 1;
                        uart_tx  <= tx_shift[1];
                    end
                end else begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
                default: if (tx_cnt == BIT_LAST) tx_state <= IDLE;
                    else tx_cnt <= tx_cnt + 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= IDLE;
            rx_sync  <= 2'b11;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            if (rx_rd) rx_valid <= 1'b0;
            case (rx_state)
                IDLE: if (!rx_sync[1]) begin
                    rx_state <= START;
                    rx_cnt   <= '0;
                end
                START: if (rx_cnt == BIT_HALF) begin  // Middle of start bit.
                    rx_state <= rx_sync[1] ? IDLE : DATA;
                    rx_cnt   <= '0;
                    rx_bits  <= '0;
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
                DATA: if (rx_cnt == BIT_LAST) begin
                    rx_cnt   <= '0;
                    rx_shift <= {rx_sync[1], rx_shift[7:1]};
                    rx_bits  <= rx_bits + 1'b1;
                    if (rx_bits == 3'd7) rx_state <= STOP;
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
                default: if (rx_cnt == BIT_LAST) begin
                    rx_state <= IDLE;
                    if (rx_sync[1]) begin  // Valid stop bit.
                        rx_data  <= rx_shift;
                        rx_valid <= 1'b1;
                    end
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) tx_state == IDLE |-> uart_tx)
        else $error("TX line low while transmitter idle.");

endmodule

`default_nettype wire

/* design/axil_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_ram import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  axil_aw_t   aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_resp_t bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_ar_t   ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready
);
    axil_data_t mem [RAM_WORDS];

    // AW and W are taken together.
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = arvalid && !rvalid;
    assign bresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (awready) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (arready) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            for (int i = 0; i < $bits(axil_strb_t); i++) begin
                if (w.strb[i]) begin
                    mem[aw.addr[$clog2(RAM_WORDS)+1:2]][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
        if (arready) r <= '{data: mem[ar.addr[$clog2(RAM_WORDS)+1:2]], resp: RESP_OKAY};
    end

    assert property (@(posedge clk) disable iff (rst) $rose(rvalid) |-> $past(arvalid && arready))
        else $error("Read data raised without an address transfer.");

endmodule

`default_nettype wire

/* design/boot_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module boot_rom import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  axil_aw_t   aw,
    input  logic       awvalid,
    output logic       awready,
    input  axil_w_t    w,
    input  logic       wvalid,
    output logic       wready,
    output axil_resp_t bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_ar_t   ar,
    input  logic       arvalid,
    output logic       arready,
    output axil_r_t    r,
    output logic       rvalid,
    input  logic       rready
);
    axil_data_t mem [ROM_WORDS];

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = arvalid && !rvalid;
    assign bresp   = RESP_SLVERR;  // Contents never change.

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (awready) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (arready) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arready) r <= '{data: mem[ar.addr[$clog2(ROM_WORDS)+1:2]], resp: RESP_OKAY};
    end

endmodule

`default_nettype wire

/* design/axil_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_decoder import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  axil_aw_t   s_aw,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  axil_w_t    s_w,
    input  logic       s_wvalid,
    output logic       s_wready,
    output axil_resp_t s_bresp,
    output logic       s_bvalid,
    input  logic       s_bready,
    input  axil_ar_t   s_ar,
    input  logic       s_arvalid,
    output logic       s_arready,
    output axil_r_t    s_r,
    output logic       s_rvalid,
    input  logic       s_rready,

    output axil_aw_t   rom_aw,
    output logic       rom_awvalid,
    input  logic       rom_awready,
    output axil_w_t    rom_w,
    output logic       rom_wvalid,
    input  logic       rom_wready,
    input  axil_resp_t rom_bresp,
    input  logic       rom_bvalid,
    output logic       rom_bready,
    output axil_ar_t   rom_ar,
    output logic       rom_arvalid,
    input  logic       rom_arready,
    input  axil_r_t    rom_r,
    input  logic       rom_rvalid,
    output logic       rom_rready,

    output axil_aw_t   ram_aw,
    output logic       ram_awvalid,
    input  logic       ram_awready,
    output axil_w_t    ram_w,
    output logic       ram_wvalid,
    input  logic       ram_wready,
    input  axil_resp_t ram_bresp,
    input  logic       ram_bvalid,
    output logic       ram_bready,
    output axil_ar_t   ram_ar,
    output logic       ram_arvalid,
    input  logic       ram_arready,
    input  axil_r_t    ram_r,
    input  logic       ram_rvalid,
    output logic       ram_rready,

    output axil_aw_t   uart_aw,
    output logic       uart_awvalid,
    input  logic       uart_awready,
    output axil_w_t    uart_w,
    output logic       uart_wvalid,
    input  logic       uart_wready,
    input  axil_resp_t uart_bresp,
    input  logic       uart_bvalid,
    output logic       uart_bready,
    output axil_ar_t   uart_ar,
    output logic       uart_arvalid,
    input  logic       uart_arready,
    input  axil_r_t    uart_r,
    input  logic       uart_rvalid,
    output logic       uart_rready
);
    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RESP, RESPOND} dec_state_t;

    dec_state_t state;
    logic       req_write;  // Held transaction is a write.
    axil_aw_t   req_a;
    axil_w_t    req_w;
    region_t    sel;
    axil_r_t    resp_q;
    region_t    acc_sel;
    logic       wr_acc;
    logic       rd_acc;
    logic [2:0] hit;
    logic       tgt_accept;
    logic       tgt_done;
    axil_resp_t tgt_bresp;
    axil_r_t    tgt_r;

    // Write wins over a pending read.
    assign wr_acc    = state == IDLE && s_awvalid && s_wvalid;
    assign rd_acc    = state == IDLE && s_arvalid && !(s_awvalid && s_wvalid);
    assign s_awready = wr_acc;
    assign s_wready  = wr_acc;
    assign s_arready = rd_acc;

    always_comb begin
        case (wr_acc ? s_aw.addr[31:28] : s_ar.addr[31:28])
            REGION_ROM:  acc_sel = ROM;
            REGION_RAM:  acc_sel = RAM;
            REGION_UART: acc_sel = UART;
            default:     acc_sel = NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (wr_acc || rd_acc) state <= (acc_sel == NONE) ? RESPOND : REQUEST;
                REQUEST:   if (tgt_accept) state <= WAIT_RESP;
                WAIT_RESP: if (tgt_done) state <= RESPOND;
                RESPOND:   if ((s_bvalid && s_bready) || (s_rvalid && s_rready)) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc || rd_acc) begin
            req_write <= wr_acc;
            req_a     <= wr_acc ? s_aw : axil_aw_t'(s_ar);
            req_w     <= s_w;
            sel       <= acc_sel;
            resp_q    <= '{data: '0, resp: RESP_DECERR};  // Kept only when unmapped.
        end else if (state == WAIT_RESP && tgt_done) begin
            resp_q <= tgt_r;
            if (req_write) resp_q.resp <= tgt_bresp;
        end
    end

    assign hit = {sel == UART, sel == RAM, sel == ROM};

    assign {uart_aw, ram_aw, rom_aw} = {3{req_a}};
    assign {uart_w, ram_w, rom_w}    = {3{req_w}};
    assign {uart_ar, ram_ar, rom_ar} = {3{axil_ar_t'(req_a)}};

    assign {uart_awvalid, ram_awvalid, rom_awvalid} = {3{state == REQUEST && req_write}} & hit;
    assign {uart_wvalid, ram_wvalid, rom_wvalid}    = {3{state == REQUEST && req_write}} & hit;
    assign {uart_arvalid, ram_arvalid, rom_arvalid} = {3{state == REQUEST && !req_write}} & hit;
    assign {uart_bready, ram_bready, rom_bready}    = {3{state == WAIT_RESP && req_write}} & hit;
    assign {uart_rready, ram_rready, rom_rready}    = {3{state == WAIT_RESP && !req_write}} & hit;

    // Return path from the selected target.
    always_comb begin
        case (sel)
            ROM: begin
                tgt_accept = req_write ? rom_awready && rom_wready : rom_arready;
                tgt_done   = req_write ? rom_bvalid : rom_rvalid;
                tgt_bresp  = rom_bresp;
                tgt_r      = rom_r;
            end
            RAM: begin
                tgt_accept = req_write ? ram_awready && ram_wready : ram_arready;
                tgt_done   = req_write ? ram_bvalid : ram_rvalid;
                tgt_bresp  = ram_bresp;
                tgt_r      = ram_r;
            end
            UART: begin
                tgt_accept = req_write ? uart_awready && uart_wready : uart_arready;
                tgt_done   = req_write ? uart_bvalid : uart_rvalid;
                tgt_bresp  = uart_bresp;
                tgt_r      = uart_r;
            end
            default: begin
                tgt_accept = 1'b0;
                tgt_done   = 1'b0;
                tgt_bresp  = RESP_DECERR;
                tgt_r      = '{data: '0, resp: RESP_DECERR};
            end
        endcase
    end

    assign s_bvalid = state == RESPOND && req_write;
    assign s_rvalid = state == RESPOND && !req_write;
    assign s_bresp  = resp_q.resp;
    assign s_r      = resp_q;

    assert property (@(posedge clk) disable iff (rst) s_bvalid && !s_bready |=> s_bvalid)
        else $error("Write response withdrawn before bready.");

endmodule

`default_nettype wire

/* design/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    typedef struct packed {
        axil_addr_t addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    typedef struct packed {
        axil_addr_t addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;
    localparam axil_resp_t RESP_DECERR = 2'd3;

    // Top address nibble of each target.
    localparam logic [3:0] REGION_ROM  = 4'h0;
    localparam logic [3:0] REGION_RAM  = 4'h1;
    localparam logic [3:0] REGION_UART = 4'h3;

    typedef enum logic [1:0] {ROM, RAM, UART, NONE} region_t;

    localparam int    ROM_WORDS = 16;
    localparam int    RAM_WORDS = 1024;
    localparam string ROM_FILE  = "boot_rom.hex";

    localparam int CLKS_PER_BIT = 8;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
    typedef logic [7:0] uart_byte_t;

    localparam baud_cnt_t BIT_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t BIT_HALF = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

    localparam axil_addr_t UART_TXDATA = 32'h0;
    localparam axil_addr_t UART_STATUS = 32'h4;
    localparam axil_addr_t UART_RXDATA = 32'h8;

endpackage

`default_nettype wire
